// ==== rtl/mfcc_settings.svh ====
`ifndef MFCC_SETTINGS_SVH
`define MFCC_SETTINGS_SVH

`default_nettype none

// framing
`define MFCC_FRAME_SIZE 16          // samples per frame
`define MFCC_FRAME_MOVE 8           // hop between frame starts

// buffering
`define MFCC_SAMPLE_FIFO_DEPTH 16   // entries between filter and framer
`define MFCC_RESULT_FIFO_DEPTH 4    // finished frames awaiting output

// pre-emphasis coefficient, 0.97 in Q1.15
`define MFCC_ALPHA 31785

`default_nettype wire

`endif

// ==== rtl/mfcc_pkg.sv ====
`include "mfcc_settings.svh"
`default_nettype none

package mfcc_pkg;

    typedef logic signed [15:0] sample_t;    // pcm sample
    typedef logic [39:0]        energy_t;    // sum of squares over a frame
    typedef logic [15:0]        frame_idx_t; // wraps
    typedef logic [15:0]        win_coef_t;  // unsigned Q1.15

    typedef logic [$clog2(`MFCC_FRAME_SIZE)-1:0]   frame_pos_t; // position in a frame
    typedef logic [$clog2(`MFCC_FRAME_SIZE+1)-1:0] frame_len_t; // 1 .. frame size

    typedef struct packed {
        energy_t    energy;
        frame_idx_t idx;
    } frame_result_t;

    localparam real PI = 3.14159265358979323846;

    // 32768 * (0.54 - 0.46 cos(2 pi k / (N - 1))), rounded to nearest
    function automatic win_coef_t hamming_coef(input int k);
        real c;
        c = 32768.0 * (0.54 - 0.46 * $cos(2.0 * PI * k / (`MFCC_FRAME_SIZE - 1)));
        return win_coef_t'($rtoi(c + 0.5));
    endfunction

endpackage

`default_nettype wire

// ==== rtl/pre_emphasis.sv ====
`timescale 1ns/1ps
`include "mfcc_settings.svh"
`default_nettype none

module pre_emphasis (
    input  logic              clk,
    input  logic              rst_i,
    input  mfcc_pkg::sample_t x_i,
    input  logic              x_valid_i,
    output logic              x_ready_o,
    output mfcc_pkg::sample_t y_o,
    output logic              y_valid_o,
    input  logic              y_ready_i
);
    import mfcc_pkg::*;

    localparam logic signed [16:0] ALPHA = 17'(`MFCC_ALPHA);

    sample_t            x_prev_q;   // last accepted input
    logic signed [32:0] prod;
    logic signed [17:0] diff;
    sample_t            y_d;
    logic               accept;

    assign x_ready_o = !y_valid_o || y_ready_i; // register empty or draining
    assign accept    = x_valid_i && x_ready_o;

    assign prod = ALPHA * x_prev_q;
    assign diff = 18'(x_i) - 18'(prod >>> 15);

    // clamp to the 16-bit signed range
    always_comb begin
        if (diff > 18'sd32767) begin
            y_d = 16'sh7fff;
        end else if (diff < -18'sd32768) begin
            y_d = 16'sh8000;
        end else begin
            y_d = diff[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            y_valid_o <= 1'b0;
            x_prev_q  <= '0;
        end else if (accept) begin
            y_valid_o <= 1'b1;
            x_prev_q  <= x_i;
        end else if (y_ready_i) begin
            y_valid_o <= 1'b0; // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            y_o <= y_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sample_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
    parameter type T_DATA = mfcc_pkg::sample_t,
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  rst_i,
    input  T_DATA wr_data_i,
    input  logic  wr_valid_i,
    output logic  wr_ready_o,
    output T_DATA rd_data_o,
    output logic  rd_valid_o,
    input  logic  rd_ready_i,
    output logic  full_o
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T_DATA         mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          wr_fire;
    logic          rd_fire;

    assign full_o     = (count_q == CW'(DEPTH));
    assign wr_ready_o = !full_o;
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = mem[rd_ptr_q]; // head entry, shown without a read request

    assign wr_fire = wr_valid_i && wr_ready_o;
    assign rd_fire = rd_valid_o && rd_ready_i;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CW'(wr_fire) - CW'(rd_fire); // both may fire at once
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
`timescale 1ns/1ps
`include "mfcc_settings.svh"
`default_nettype none

module frame_buffer (
    input  logic                 clk,
    input  logic                 rst_i,
    input  mfcc_pkg::sample_t    wr_data_i,
    input  logic                 wr_en_i,
    input  logic                 rd_en_i,
    input  mfcc_pkg::frame_pos_t rd_offset_i,
    output mfcc_pkg::sample_t    rd_data_o,
    output logic                 rd_valid_o,
    output mfcc_pkg::frame_pos_t rd_pos_o
);
    import mfcc_pkg::*;

    localparam int DEPTH = 2 ** $bits(frame_pos_t); // ring wraps on the pointer width

    sample_t    mem [DEPTH];
    frame_pos_t wr_ptr_q;
    frame_pos_t rd_base;
    frame_pos_t rd_addr;

    // oldest of the last N samples; no writes happen during readout
    assign rd_base = wr_ptr_q - frame_pos_t'(`MFCC_FRAME_SIZE);
    assign rd_addr = rd_base + rd_offset_i;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr];
            rd_pos_o  <= rd_offset_i; // window position travels with the data
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q   <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            if (wr_en_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            rd_valid_o <= rd_en_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_counter.sv ====
`timescale 1ns/1ps
`include "mfcc_settings.svh"
`default_nettype none

module frame_counter (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 load_i,
    input  mfcc_pkg::frame_len_t load_value_i,
    input  logic                 step_i,
    output mfcc_pkg::frame_pos_t count_o,
    output logic                 last_o
);
    import mfcc_pkg::*;

    frame_pos_t count_q;
    frame_len_t target_q;

    assign count_o = count_q;
    assign last_o  = (frame_len_t'(count_q) == target_q - 1'b1); // final step pending

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q  <= '0;
            target_q <= frame_len_t'(`MFCC_FRAME_SIZE); // first fill is a whole frame
        end else if (load_i) begin
            count_q  <= '0;
            target_q <= load_value_i;
        end else if (step_i) begin
            count_q <= last_o ? '0 : count_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_ctrl.sv ====
`timescale 1ns/1ps
`include "mfcc_settings.svh"
`default_nettype none

module frame_ctrl (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 fifo_valid_i,
    output logic                 fill_en_o,
    output logic                 rd_en_o,
    output logic                 frame_last_o,
    output logic                 cnt_load_o,
    output mfcc_pkg::frame_len_t cnt_value_o,
    output logic                 cnt_step_o,
    input  logic                 cnt_last_i,
    input  logic                 energy_done_i,
    input  logic                 result_full_i
);
    import mfcc_pkg::*;

    typedef enum logic [1:0] {
        FILL,
        READ,
        FLUSH
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   done_seen_q;    // energy for this frame emitted
    logic   wr_fire;
    logic   fill_end;
    logic   flush_end;

    assign wr_fire    = fill_en_o && fifo_valid_i;
    assign fill_end   = wr_fire && cnt_last_i;
    // waits a cycle after the push so full reflects the new entry
    assign flush_end  = (state_q == FLUSH) && done_seen_q && !result_full_i;
    assign cnt_step_o = wr_fire || rd_en_o; // only on real transfers
    assign cnt_load_o = fill_end || flush_end;

    // readout length when leaving FILL or fill target when leaving FLUSH
    assign cnt_value_o = (state_q == FILL) ?
                         frame_len_t'(`MFCC_FRAME_SIZE) : frame_len_t'(`MFCC_FRAME_MOVE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            FILL:    if (fill_end) state_d = READ;
            READ:    if (rd_en_o && cnt_last_i) state_d = FLUSH;
            FLUSH:   if (flush_end) state_d = FILL;
            default: state_d = FILL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= FILL;
            fill_en_o    <= 1'b0;
            rd_en_o      <= 1'b0;
            frame_last_o <= 1'b0;
            done_seen_q  <= 1'b0;
        end else begin
            state_q      <= state_d;
            fill_en_o    <= (state_d == FILL);
            rd_en_o      <= (state_d == READ);
            frame_last_o <= rd_en_o && cnt_last_i; // lines up with buffer read data
            if (flush_end) begin
                done_seen_q <= 1'b0;
            end else if (energy_done_i) begin
                done_seen_q <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/frame_energy.sv ====
`timescale 1ns/1ps
`include "mfcc_settings.svh"
`default_nettype none

module frame_energy (
    input  logic                    clk,
    input  logic                    rst_i,
    input  mfcc_pkg::sample_t       sample_i,
    input  logic                    valid_i,
    input  mfcc_pkg::frame_pos_t    pos_i,
    input  logic                    last_i,
    output mfcc_pkg::frame_result_t result_o,
    output logic                    result_valid_o,
    output logic                    done_o
);
    import mfcc_pkg::*;

    win_coef_t          coef_rom [`MFCC_FRAME_SIZE];
    logic signed [32:0] prod;
    sample_t            win_d;
    sample_t            win_q;    // windowed sample
    logic signed [31:0] sq_d;
    logic [31:0]        sq_q;     // squared sample
    logic               v1_q, l1_q;
    logic               v2_q, l2_q;
    energy_t            acc_q;
    energy_t            acc_sum;
    frame_idx_t         idx_q;

    for (genvar k = 0; k < `MFCC_FRAME_SIZE; k++) begin : g_coef
        assign coef_rom[k] = hamming_coef(k);
    end

    assign prod    = sample_i * $signed({1'b0, coef_rom[pos_i]});
    assign win_d   = sample_t'(prod >>> 15); // truncating Q1.15 rescale
    assign sq_d    = win_q * win_q;
    assign acc_sum = acc_q + energy_t'(sq_q);
    assign done_o  = result_valid_o;

    always_ff @(posedge clk) begin
        if (valid_i) begin
            win_q <= win_d;
        end
        if (v1_q) begin
            sq_q <= sq_d;
        end
        if (v2_q && l2_q) begin
            result_o.energy <= acc_sum;
            result_o.idx    <= idx_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            v1_q           <= 1'b0;
            l1_q           <= 1'b0;
            v2_q           <= 1'b0;
            l2_q           <= 1'b0;
            acc_q          <= '0;
            idx_q          <= '0;
            result_valid_o <= 1'b0;
        end else begin
            v1_q           <= valid_i;
            l1_q           <= valid_i && last_i;
            v2_q           <= v1_q;
            l2_q           <= v1_q && l1_q;
            result_valid_o <= v2_q && l2_q;
            if (v2_q) begin
                if (l2_q) begin
                    acc_q <= '0;           // next frame starts clean
                    idx_q <= idx_q + 1'b1;
                end else begin
                    acc_q <= acc_sum;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mfcc_front.sv ====
`timescale 1ns/1ps
`include "mfcc_settings.svh"
`default_nettype none

module mfcc_front (
    input  logic                 clk,
    input  logic                 rst_i,
    input  mfcc_pkg::sample_t    sample_i,
    input  logic                 sample_valid_i,
    output logic                 sample_ready_o,
    output mfcc_pkg::energy_t    energy_o,
    output mfcc_pkg::frame_idx_t frame_idx_o,
    output logic                 frame_valid_o,
    input  logic                 frame_ready_i
);
    import mfcc_pkg::*;

    sample_t       pe_data;
    logic          pe_valid, pe_ready;
    sample_t       fifo_data;
    logic          fifo_valid;
    logic          fill_en, rd_en;
    logic          load, step, last;
    frame_len_t    load_value;
    frame_pos_t    count;
    sample_t       rd_data;
    logic          rd_valid;
    frame_pos_t    rd_offset;
    logic          frame_last;
    frame_result_t result;
    logic          result_valid;
    logic          energy_done;
    logic          result_full;
    frame_result_t res_data;

    pre_emphasis u_pre_emphasis (
        .clk       (clk),
        .rst_i     (rst_i),
        .x_i       (sample_i),
        .x_valid_i (sample_valid_i),
        .x_ready_o (sample_ready_o),
        .y_o       (pe_data),
        .y_valid_o (pe_valid),
        .y_ready_i (pe_ready)
    );

    sample_fifo #(.T_DATA(sample_t), .DEPTH(`MFCC_SAMPLE_FIFO_DEPTH)) u_sample_fifo (
        .clk        (clk),
        .rst_i      (rst_i),
        .wr_data_i  (pe_data),
        .wr_valid_i (pe_valid),
        .wr_ready_o (pe_ready),
        .rd_data_o  (fifo_data),
        .rd_valid_o (fifo_valid),
        .rd_ready_i (fill_en),   // drained only while filling
        .full_o     ()
    );

    frame_buffer u_frame_buffer (
        .clk         (clk),
        .rst_i       (rst_i),
        .wr_data_i   (fifo_data),
        .wr_en_i     (fill_en && fifo_valid),
        .rd_en_i     (rd_en),
        .rd_offset_i (count),
        .rd_data_o   (rd_data),
        .rd_valid_o  (rd_valid),
        .rd_pos_o    (rd_offset)
    );

    frame_counter u_frame_counter (
        .clk          (clk),
        .rst_i        (rst_i),
        .load_i       (load),
        .load_value_i (load_value),
        .step_i       (step),
        .count_o      (count),
        .last_o       (last)
    );

    frame_ctrl u_frame_ctrl (
        .clk           (clk),
        .rst_i         (rst_i),
        .fifo_valid_i  (fifo_valid),
        .fill_en_o     (fill_en),
        .rd_en_o       (rd_en),
        .frame_last_o  (frame_last),
        .cnt_load_o    (load),
        .cnt_value_o   (load_value),
        .cnt_step_o    (step),
        .cnt_last_i    (last),
        .energy_done_i (energy_done),
        .result_full_i (result_full)
    );

    frame_energy u_frame_energy (
        .clk            (clk),
        .rst_i          (rst_i),
        .sample_i       (rd_data),
        .valid_i        (rd_valid),
        .pos_i          (rd_offset),
        .last_i         (frame_last),
        .result_o       (result),
        .result_valid_o (result_valid),
        .done_o         (energy_done)
    );

    // space is guaranteed by frame_ctrl before each frame starts
    sample_fifo #(.T_DATA(frame_result_t), .DEPTH(`MFCC_RESULT_FIFO_DEPTH)) u_result_fifo (
        .clk        (clk),
        .rst_i      (rst_i),
        .wr_data_i  (result),
        .wr_valid_i (result_valid),
        .wr_ready_o (),
        .rd_data_o  (res_data),
        .rd_valid_o (frame_valid_o),
        .rd_ready_i (frame_ready_i),
        .full_o     (result_full)
    );

    assign energy_o    = res_data.energy;
    assign frame_idx_o = res_data.idx;

endmodule

`default_nettype wire

// ==== test/mfcc_front_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module mfcc_front_sva (
    input logic                 clk,
    input logic                 rst_i,
    input mfcc_pkg::sample_t    sample_i,
    input logic                 sample_valid_i,
    input logic                 sample_ready_o,
    input mfcc_pkg::energy_t    energy_o,
    input mfcc_pkg::frame_idx_t frame_idx_o,
    input logic                 frame_valid_o,
    input logic                 frame_ready_i,
    input logic                 fill_en,
    input logic                 rd_en,
    input logic                 result_valid,
    input logic                 result_full
);

    input_hold: assert property (@(posedge clk) disable iff (rst_i)
        sample_valid_i && !sample_ready_o |=> sample_valid_i && $stable(sample_i))
        else $error("input sample dropped or changed while stalled");

    output_hold: assert property (@(posedge clk) disable iff (rst_i)
        frame_valid_o && !frame_ready_i |=>
            frame_valid_o && $stable(energy_o) && $stable(frame_idx_o))
        else $error("output frame dropped or changed while stalled");

    // the buffer is written and read in separate phases
    fill_read_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(fill_en && rd_en))
        else $error("fill_en and rd_en high together");

    result_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        result_valid |-> !result_full)
        else $error("result pushed into a full result FIFO");

endmodule

bind mfcc_front mfcc_front_sva u_sva (
    .clk            (clk),
    .rst_i          (rst_i),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .sample_ready_o (sample_ready_o),
    .energy_o       (energy_o),
    .frame_idx_o    (frame_idx_o),
    .frame_valid_o  (frame_valid_o),
    .frame_ready_i  (frame_ready_i),
    .fill_en        (fill_en),
    .rd_en          (rd_en),
    .result_valid   (result_valid),
    .result_full    (result_full)
);

`default_nettype wire

// ==== test/mfcc_front_tb.sv ====
`timescale 1ns/1ps
`include "mfcc_settings.svh"
`default_nettype none

module mfcc_front_tb;
    import mfcc_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int N             = `MFCC_FRAME_SIZE;
    localparam int HOP           = `MFCC_FRAME_MOVE;
    localparam int TOTAL_SAMPLES = 16 + 80 + 32 + 80 + 80 + 28 + 16; // all tests together

    logic       clk = 1'b0;
    logic       rst_i;
    sample_t    sample_i;
    logic       sample_valid_i;
    logic       sample_ready_o;
    energy_t    energy_o;
    frame_idx_t frame_idx_o;
    logic       frame_valid_o;
    logic       frame_ready_i = 1'b1;

    sample_t    stim_q[$];       // samples of the running test
    sample_t    pe_ref[$];       // filtered copy of stim_q
    sample_t    stream_q[$];     // 80-sample stream, replayed with gaps
    sample_t    single_q[$];     // single frame data, replayed after reset
    energy_t    exp_energy_q[$];
    frame_idx_t exp_idx_q[$];
    string      test_name;
    bit         stall_en = 1'b0;
    int         n_frames_seen = 0; // also read position in the expected queues
    int         n_ready_drops = 0;
    int         n_checks = 0;
    int         n_errors = 0;
    int         n_main_errors = 0;
    int         n_tests = 0;
    int         n_failed = 0;

    mfcc_front UUT (
        .clk            (clk),
        .rst_i          (rst_i),
        .sample_i       (sample_i),
        .sample_valid_i (sample_valid_i),
        .sample_ready_o (sample_ready_o),
        .energy_o       (energy_o),
        .frame_idx_o    (frame_idx_o),
        .frame_valid_o  (frame_valid_o),
        .frame_ready_i  (frame_ready_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // y = x - (alpha * x_prev >>> 15), clamped to 16 bits
    function automatic sample_t pre_emph_ref(input sample_t x, input sample_t prev);
        longint y;
        y = longint'(x) - ((longint'(`MFCC_ALPHA) * longint'(prev)) >>> 15);
        if (y > 32767) begin
            y = 32767;
        end else if (y < -32768) begin
            y = -32768;
        end
        return sample_t'(y);
    endfunction

    function automatic longint window_coef_ref(input int k);
        real c;
        c = 32768.0 * (0.54 - 0.46 * $cos(2.0 * 3.14159265358979 * k / (N - 1)));
        return longint'($rtoi(c + 0.5));
    endfunction

    // sum of squared windowed samples, frame starting at pe_ref[start]
    function automatic energy_t frame_energy_ref(input int start);
        longint w;
        longint sum;
        sum = 0;
        for (int k = 0; k < N; k++) begin
            w   = (longint'(pe_ref[start + k]) * window_coef_ref(k)) >>> 15;
            sum = sum + w * w;
        end
        return energy_t'(sum);
    endfunction

    task automatic build_expected();
        sample_t prev;
        prev = '0;            // history is clear after reset
        pe_ref.delete();
        foreach (stim_q[i]) begin
            pe_ref.push_back(pre_emph_ref(stim_q[i], prev));
            prev = stim_q[i];
        end
        for (int s = 0; s + N <= stim_q.size(); s += HOP) begin
            exp_energy_q.push_back(frame_energy_ref(s));
            exp_idx_q.push_back(frame_idx_t'(s / HOP));
        end
    endtask

    task automatic make_random(input int count);
        int v;
        stim_q.delete();
        repeat (count) begin
            v = int'($urandom_range(16000)) - 8000;
            stim_q.push_back(sample_t'(v));
        end
    endtask

    task automatic apply_reset();
        rst_i          <= 1'b1;
        sample_valid_i <= 1'b0;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        @(posedge clk);
    endtask

    task automatic drive_samples(input bit gaps);
        int gap;
        foreach (stim_q[i]) begin
            gap = gaps ? int'($urandom_range(3)) : 0;
            repeat (gap) begin
                sample_valid_i <= 1'b0;
                @(posedge clk);
            end
            sample_i       <= stim_q[i];
            sample_valid_i <= 1'b1;
            @(posedge clk);
            while (!sample_ready_o) begin
                @(posedge clk);      // held until accepted
            end
        end
        sample_valid_i <= 1'b0;
    endtask

    task automatic wait_frames();
        while (n_frames_seen < exp_idx_q.size()) begin
            @(posedge clk);
        end
        repeat (32) @(posedge clk);  // idle window for stray frames
    endtask

    task automatic run_test(input string name, input bit gaps);
        int errs_before;
        int frames_before;
        int drops_before;
        test_name = name;
        apply_reset();
        errs_before   = n_errors + n_main_errors;
        frames_before = n_frames_seen;
        drops_before  = n_ready_drops;
        build_expected();
        drive_samples(gaps);
        wait_frames();
        if (stall_en && n_ready_drops == drops_before) begin
            $display("error in %s: sample_ready_o never fell during output stalls", name);
            n_main_errors++;
        end
        n_tests++;
        if (n_errors + n_main_errors != errs_before) begin
            n_failed++;
        end
        $display("test %-14s %s, %0d frames", name,
                 (n_errors + n_main_errors == errs_before) ? "pass" : "fail",
                 n_frames_seen - frames_before);
    endtask

    task automatic check_energy(input string name, input energy_t expected,
                                input energy_t actual);
        n_checks++;
        if (actual !== expected) begin
            $display("mismatch %s energy: expected %0d, actual %0d", name, expected, actual);
            n_errors++;
        end
    endtask

    task automatic check_index(input string name, input frame_idx_t expected,
                               input frame_idx_t actual);
        n_checks++;
        if (actual !== expected) begin
            $display("mismatch %s index: expected %0d, actual %0d", name, expected, actual);
            n_errors++;
        end
    endtask

    // output side, one comparison per accepted frame
    always @(posedge clk) begin
        if (!rst_i && frame_valid_o && frame_ready_i) begin
            if (n_frames_seen >= exp_idx_q.size()) begin
                $display("error in %s: frame %0d arrived with no frame expected",
                         test_name, frame_idx_o);
                n_errors++;
            end else begin
                check_energy(test_name, exp_energy_q[n_frames_seen], energy_o);
                check_index(test_name, exp_idx_q[n_frames_seen], frame_idx_o);
                n_frames_seen++;
            end
        end
        if (stall_en && sample_valid_i && !sample_ready_o) begin
            n_ready_drops++;
        end
    end

    always @(posedge clk) begin
        frame_ready_i <= stall_en ? ($urandom_range(47) == 0) : 1'b1; // long random stalls
    end

    initial begin
        #(TOTAL_SAMPLES * 40 * CLK_PERIOD);
        $display("timeout in %s: %0d expected frames went missing", test_name,
                 exp_idx_q.size() - n_frames_seen);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(47));
        rst_i          = 1'b1;
        sample_i       = '0;
        sample_valid_i = 1'b0;

        make_random(16);
        single_q = stim_q;
        run_test("single_frame", 1'b0);

        make_random(80);
        stream_q = stim_q;
        run_test("stream_80", 1'b0);

        stim_q.delete();
        for (int i = 0; i < 32; i++) begin
            stim_q.push_back((i % 2 == 0) ? 16'sh7fff : 16'sh8000); // full-scale swing
        end
        run_test("saturation", 1'b0);

        make_random(80);
        stall_en = 1'b1;
        run_test("output_stall", 1'b0);
        stall_en = 1'b0;

        stim_q = stream_q;
        run_test("input_gaps", 1'b1);

        make_random(28);
        run_test("midrun_prefix", 1'b0);  // leaves half a hop in the buffer
        stim_q = single_q;
        run_test("after_reset", 1'b0);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed,
                 n_checks, n_errors + n_main_errors);
        if (n_errors + n_main_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/mfcc_pkg.sv
rtl/pre_emphasis.sv
rtl/sample_fifo.sv
rtl/frame_buffer.sv
rtl/frame_counter.sv
rtl/frame_ctrl.sv
rtl/frame_energy.sv
rtl/mfcc_front.sv
test/mfcc_front_sva.sv
test/mfcc_front_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mfcc_front_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "result: fail"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "result: incomplete run"; exit 1; fi
	@echo "result: pass"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
